// ==== verilog/dcf77_defines.svh ====
// ================================================
// DCF77 subsystem constants
// tick rates, pulse and gap thresholds, and the
// APB register map of the time block
// ================================================
`ifndef DCF77_DEFINES_SVH
`define DCF77_DEFINES_SVH

// receiver timing, in 10 ms ticks
`define DCF77_TICKS_PER_SEC 7'd100 // one second of ticks
`define DCF77_BIT_THRESHOLD 5'd15  // pulse at or above this is a 1
`define DCF77_GAP_TICKS     8'd150 // edge gap above this is a minute mark

// APB register map, byte addresses
`define APB_ADDR_STATUS   8'h00 // flags and frame counters
`define APB_ADDR_CTRL     8'h04 // bit 0 clears the counters
`define APB_ADDR_TIME     8'h08 // second, minute, hour
`define APB_ADDR_DATE     8'h0C // day, weekday, month, year
`define APB_ADDR_FRAME_LO 8'h10 // raw frame 31:0
`define APB_ADDR_FRAME_HI 8'h14 // raw frame 58:32

`endif

// ==== verilog/dcf77_frame_pkg.sv ====
// ================================================
// DCF77 frame types
// bit layout of the 59-bit minute frame and the
// receiver status seen by the rest of the design
// ================================================
package dcf77_frame_pkg;

	// field layout, bit 58 first down to bit 0
	typedef struct packed {
		logic       p3;          // even parity over the date
		logic [7:0] year;        // BCD, years of century
		logic [4:0] month;       // BCD
		logic [2:0] day_of_week; // 1 is monday
		logic [5:0] day;         // BCD day of month
		logic       p2;          // even parity over hour
		logic [5:0] hour;        // BCD
		logic       p1;          // even parity over minute
		logic [6:0] minute;      // BCD
		logic       time_start;  // always 1
		logic       a2;          // leap second announce
		logic       z2;          // CET
		logic       z1;          // CEST
		logic       a1;          // zone change announce
		logic       r;           // call bit
		logic [13:0] broadcast;  // weather and civil warning bits
		logic       start_bit;   // always 0
	} dcf77_fields_t;

	// one word, seen raw by the shifter and by field by the checks
	typedef union packed {
		logic [58:0]   raw;
		dcf77_fields_t fields;
	} dcf77_frame_u;

	typedef struct packed {
		logic frame_valid; // one clk, good frame at minute mark
		logic frame_error; // sticky until the next minute mark
		logic frame_done;  // one clk at every minute mark
	} rx_status_t;

endpackage

// ==== verilog/clock_pkg.sv ====
// ================================================
// Calendar and bus types
// BCD calendar time, APB request and response,
// and the shared BCD counter step
// ================================================
package clock_pkg;

	typedef struct packed {
		logic [6:0] second;      // BCD 00..59
		logic [6:0] minute;      // BCD 00..59
		logic [5:0] hour;        // BCD 00..23
		logic [5:0] day;         // BCD 01..31
		logic [2:0] day_of_week; // 1..7
		logic [4:0] month;       // BCD 01..12
		logic [7:0] year;        // BCD 00..99
		logic       locked;      // set by the first valid frame
	} cal_time_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// two-digit BCD step, wraps to 00 after last
	function automatic logic [7:0] bcd_inc(input logic [7:0] val, input logic [7:0] last);
		logic [7:0] res;
		if (val == last)
			res = 8'h00;
		else if (val[3:0] == 4'h9)
			res = {val[7:4] + 4'h1, 4'h0};
		else
			res = {val[7:4], val[3:0] + 4'h1};
		return res;
	endfunction

endpackage

// ==== verilog/dcf77_receiver.sv ====
// ================================================
// DCF77 receiver
// samples the demodulated pulse on the 10 ms tick,
// decodes bits by pulse width, finds the minute
// mark and checks the frame before handing it on
// ================================================
`timescale 1ns/10ps
`include "dcf77_defines.svh"

module dcf77_receiver
	import dcf77_frame_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         tick,      // 10 ms clock enable
	input  logic         rx,        // 100 ms pulse is 0, 200 ms is 1
	output dcf77_frame_u frame,
	output rx_status_t   rx_status
);

	logic [1:0]    rx_sync;   // two-flop synchronizer
	logic [2:0]    rx_win;    // last three samples
	logic          majority;
	logic [1:0]    rx_d;      // [0] newest majority sample
	logic [4:0]    pulse_cnt; // high time of current pulse
	logic          bit_val;
	logic          shift_en;
	logic [7:0]    gap_cnt;   // ticks since last rising edge
	logic          mark;      // minute mark seen
	logic [5:0]    bit_cnt;   // bits since last mark
	dcf77_frame_u  shift_q;
	dcf77_frame_u  hold_q;
	dcf77_fields_t fld;
	logic          error_q;
	logic          valid_q;
	logic          done_q;
	logic          par_ok;
	logic          marks_ok;
	logic          time_ok;
	logic          date_ok;
	logic          frame_ok;

	assign majority = (rx_win[0] & rx_win[1]) | (rx_win[1] & rx_win[2]) | (rx_win[0] & rx_win[2]);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_sync   <= '0;
			rx_win    <= '0;
			rx_d      <= '0;
			pulse_cnt <= '0;
			bit_val   <= 1'b0;
			shift_en  <= 1'b0;
			gap_cnt   <= '0;
			mark      <= 1'b0;
			bit_cnt   <= '0;
			hold_q    <= '0;
			error_q   <= 1'b1;
			valid_q   <= 1'b0;
			done_q    <= 1'b0;
		end
		else
		begin
			rx_sync <= {rx_sync[0], rx};
			if (tick)
			begin
				rx_win   <= {rx_win[1:0], rx_sync[1]};
				rx_d     <= {rx_d[0], majority};
				shift_en <= 1'b0;
				mark     <= 1'b0;
				valid_q  <= 1'b0;
				done_q   <= 1'b0;

				if (rx_d == 2'b11 && pulse_cnt != 5'h1f)
					pulse_cnt <= pulse_cnt + 5'd1;
				else if (rx_d == 2'b10) // falling edge ends the bit
				begin
					bit_val   <= (pulse_cnt >= `DCF77_BIT_THRESHOLD);
					shift_en  <= 1'b1;
					pulse_cnt <= '0;
				end

				if (rx_d == 2'b01) // rising edge
				begin
					mark    <= (gap_cnt > `DCF77_GAP_TICKS);
					gap_cnt <= '0;
				end
				else if (gap_cnt != 8'hff)
					gap_cnt <= gap_cnt + 8'd1;

				if (mark)
				begin
					hold_q  <= shift_q;
					error_q <= !frame_ok;
					valid_q <= frame_ok;
					done_q  <= 1'b1;
					bit_cnt <= {5'd0, shift_en};
				end
				else if (shift_en && bit_cnt != 6'h3f)
					bit_cnt <= bit_cnt + 6'd1;
			end
		end
	end

	// LSB first on air, so shift in from the top
	always_ff @(posedge clk)
	begin
		if (tick && shift_en)
			shift_q.raw <= {bit_val, shift_q.raw[58:1]};
	end

	assign fld = shift_q.fields;

	assign par_ok = !(^{fld.p1, fld.minute}) && !(^{fld.p2, fld.hour})
		&& !(^{fld.p3, fld.year, fld.month, fld.day_of_week, fld.day});
	assign marks_ok = !fld.start_bit && fld.time_start && (bit_cnt == 6'd59);
	assign time_ok = (fld.minute[6:4] < 3'd6) && (fld.minute[3:0] < 4'd10)
		&& (fld.hour[5:4] < 2'd3) && (fld.hour[3:0] < 4'd10)
		&& !(fld.hour[5:4] == 2'd2 && fld.hour[3:0] > 4'd3);
	assign date_ok = (fld.day[3:0] < 4'd10) && (fld.day != 6'h00)
		&& !(fld.day[5:4] == 2'd3 && fld.day[3:0] > 4'd1)
		&& (fld.day_of_week != 3'd0)
		&& (fld.month[3:0] < 4'd10) && (fld.month != 5'h00)
		&& !(fld.month[4] && fld.month[3:0] > 4'd2)
		&& (fld.year[7:4] < 4'd10) && (fld.year[3:0] < 4'd10);
	assign frame_ok = par_ok && marks_ok && time_ok && date_ok;

	assign frame = hold_q;

	// strobes span a whole tick period, tick cuts them to one clk
	always_comb
	begin
		rx_status.frame_valid = valid_q & tick;
		rx_status.frame_error = error_q;
		rx_status.frame_done  = done_q & tick;
	end

endmodule

// ==== verilog/local_clock.sv ====
// ================================================
// Local seconds clock
// divides the tick into BCD seconds and flags each
// minute boundary, restarted by every valid frame
// ================================================
`timescale 1ns/10ps
`include "dcf77_defines.svh"

module local_clock
	import dcf77_frame_pkg::*;
	import clock_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  rx_status_t rx_status,
	output logic [6:0] second,      // BCD
	output logic       minute_tick  // one clk at 59 to 00
);

	logic [6:0] tick_cnt; // ticks into the current second
	logic [7:0] sec_inc;

	assign sec_inc = bcd_inc({1'b0, second}, 8'h59);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tick_cnt    <= '0;
			second      <= '0;
			minute_tick <= 1'b0;
		end
		else
		begin
			minute_tick <= 1'b0;
			if (rx_status.frame_valid) // realign to the received minute
			begin
				tick_cnt <= '0;
				second   <= '0;
			end
			else if (tick)
			begin
				if (tick_cnt == `DCF77_TICKS_PER_SEC - 7'd1)
				begin
					tick_cnt    <= '0;
					second      <= sec_inc[6:0];
					minute_tick <= (second == 7'h59);
				end
				else
					tick_cnt <= tick_cnt + 7'd1;
			end
		end
	end

endmodule

// ==== verilog/time_assembler.sv ====
// ================================================
// Time assembler
// loads the calendar from each valid frame and
// keeps minutes and hours running in holdover
// ================================================
`timescale 1ns/10ps

module time_assembler
	import dcf77_frame_pkg::*;
	import clock_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  rx_status_t   rx_status,
	input  dcf77_frame_u frame,
	input  logic [6:0]   second,      // live BCD second
	input  logic         minute_tick,
	output cal_time_t    now
);

	logic [6:0] minute_q;
	logic [5:0] hour_q;
	logic [5:0] day_q;
	logic [2:0] dow_q;
	logic [4:0] month_q;
	logic [7:0] year_q;
	logic       locked_q;
	logic [7:0] min_inc;
	logic [7:0] hour_inc;

	assign min_inc  = bcd_inc({1'b0, minute_q}, 8'h59);
	assign hour_inc = bcd_inc({2'b00, hour_q}, 8'h23);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			minute_q <= '0;
			hour_q   <= '0;
			day_q    <= '0;
			dow_q    <= '0;
			month_q  <= '0;
			year_q   <= '0;
			locked_q <= 1'b0;
		end
		else if (rx_status.frame_valid) // frame beats holdover
		begin
			minute_q <= frame.fields.minute;
			hour_q   <= frame.fields.hour;
			day_q    <= frame.fields.day;
			dow_q    <= frame.fields.day_of_week;
			month_q  <= frame.fields.month;
			year_q   <= frame.fields.year;
			locked_q <= 1'b1;
		end
		else if (minute_tick)
		begin
			minute_q <= min_inc[6:0];
			if (minute_q == 7'h59)
				hour_q <= hour_inc[5:0]; // date stays put at midnight
		end
	end

	always_comb
	begin
		now.second      = locked_q ? second : 7'h00; // no time before lock
		now.minute      = minute_q;
		now.hour        = hour_q;
		now.day         = day_q;
		now.day_of_week = dow_q;
		now.month       = month_q;
		now.year        = year_q;
		now.locked      = locked_q;
	end

endmodule

// ==== verilog/apb_time_regs.sv ====
// ================================================
// APB time registers
// status, frame counters, time, date and raw frame
// on a zero wait state APB slave
// ================================================
`timescale 1ns/10ps
`include "dcf77_defines.svh"

module apb_time_regs
	import dcf77_frame_pkg::*;
	import clock_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  apb_req_t     apb_req,
	output apb_rsp_t     apb_rsp,
	input  rx_status_t   rx_status,
	input  dcf77_frame_u frame,
	input  cal_time_t    now
);

	logic        access;
	logic        mapped;
	logic        clear;
	logic [15:0] valid_cnt;
	logic [15:0] err_cnt;
	logic [13:0] err_view; // saturates in the 14-bit status field
	logic [31:0] rdata;

	assign access = apb_req.psel & apb_req.penable;
	assign clear  = access & apb_req.pwrite & (apb_req.paddr == `APB_ADDR_CTRL)
		& apb_req.pwdata[0];

	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			valid_cnt <= '0;
			err_cnt   <= '0;
		end
		else if (rx_status.frame_done)
		begin
			if (rx_status.frame_valid && valid_cnt != 16'hffff)
				valid_cnt <= valid_cnt + 16'd1;
			if (!rx_status.frame_valid && err_cnt != 16'hffff)
				err_cnt <= err_cnt + 16'd1;
		end
	end

	assign err_view = (err_cnt > 16'h3fff) ? 14'h3fff : err_cnt[13:0];

	always_comb
	begin
		mapped = 1'b1;
		case (apb_req.paddr)
			`APB_ADDR_STATUS:   rdata = {valid_cnt, err_view, now.locked, rx_status.frame_error};
			`APB_ADDR_CTRL:     rdata = 32'h0;
			`APB_ADDR_TIME:     rdata = {10'h0, now.hour, 1'b0, now.minute, 1'b0, now.second};
			`APB_ADDR_DATE:     rdata = {now.year, 3'h0, now.month, 5'h0, now.day_of_week,
				2'h0, now.day};
			`APB_ADDR_FRAME_LO: rdata = frame.raw[31:0];
			`APB_ADDR_FRAME_HI: rdata = {5'h0, frame.raw[58:32]};
			default:
			begin
				rdata  = 32'h0;
				mapped = 1'b0;
			end
		endcase
	end

	// only CTRL takes writes
	always_comb
	begin
		apb_rsp.pready  = access;
		apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : 32'h0;
		apb_rsp.pslverr = access & (!mapped
			| (apb_req.pwrite & (apb_req.paddr != `APB_ADDR_CTRL)));
	end

endmodule

// ==== verilog/dcf77_top.sv ====
// ================================================
// DCF77 time subsystem
// receiver and local clock feed the assembler,
// with an APB register block on the side
// ================================================
`timescale 1ns/10ps

module dcf77_top
	import dcf77_frame_pkg::*;
	import clock_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     tick,    // 10 ms enable
	input  logic     rx,      // demodulated carrier
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	rx_status_t   rx_status;
	dcf77_frame_u frame;
	logic [6:0]   second;
	logic         minute_tick;
	cal_time_t    now;

	dcf77_receiver u_receiver (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.rx        (rx),
		.frame     (frame),
		.rx_status (rx_status)
	);

	local_clock u_local_clock (
		.clk         (clk),
		.reset       (reset),
		.tick        (tick),
		.rx_status   (rx_status),
		.second      (second),
		.minute_tick (minute_tick)
	);

	time_assembler u_time_assembler (
		.clk         (clk),
		.reset       (reset),
		.rx_status   (rx_status),
		.frame       (frame),
		.second      (second),
		.minute_tick (minute_tick),
		.now         (now)
	);

	apb_time_regs u_apb_time_regs (
		.clk       (clk),
		.reset     (reset),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.rx_status (rx_status),
		.frame     (frame),
		.now       (now)
	);

endmodule

// ==== testbench/dcf77_tb.sv ====
// ================================================
// DCF77 subsystem testbench
// encodes frames, sends them as pulses and checks
// status, time, date and raw frame over APB
// ================================================
`timescale 1ns/10ps
`include "dcf77_defines.svh"

module dcf77_tb
	import clock_pkg::*;
();

	localparam int N_TESTS = 7;

	typedef struct packed {
		logic [6:0]  minute;
		logic [5:0]  hour;
		logic [5:0]  day;
		logic [2:0]  dow;
		logic [4:0]  month;
		logic [7:0]  year;
		logic        corrupt;    // flip p2
		logic        skip;       // no bits for a whole minute
		logic [31:0] exp_status;
		logic [31:0] exp_time;
		logic [31:0] exp_date;
	} entry_t;

	logic        clk;
	logic        reset;
	logic        tick;
	logic        rx;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	entry_t      table_q [N_TESTS];
	string       names [N_TESTS];
	logic [58:0] sent_word [N_TESTS];
	logic [31:0] rng_state;

	dcf77_top uut (
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.rx      (rx),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// 10 ms enable scaled to one clk in four
	initial
	begin
		int phase;
		phase = 0;
		forever
		begin
			@(posedge clk);
			#2 tick = (phase == 3);
			phase = (phase + 1) % 4;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// DCF77 bit positions with even parity per group
	function automatic logic [58:0] encode_frame(input entry_t e, input logic [13:0] bcast);
		logic [58:0] w;
		w        = '0;
		w[14:1]  = bcast;
		w[17]    = 1'b1; // CEST
		w[20]    = 1'b1;
		w[27:21] = e.minute;
		w[28]    = ^e.minute;
		w[34:29] = e.hour;
		w[35]    = (^e.hour) ^ e.corrupt;
		w[41:36] = e.day;
		w[44:42] = e.dow;
		w[49:45] = e.month;
		w[57:50] = e.year;
		w[58]    = ^{e.day, e.dow, e.month, e.year};
		return w;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			abort_run("value mismatch");
		end
	endtask

	task automatic set_entry(input int i, input string name, input logic [6:0] mi,
		input logic [5:0] hr, input logic [5:0] dy, input logic [2:0] wd, input logic [4:0] mo,
		input logic [7:0] yr, input logic bad, input logic skp, input logic [31:0] st,
		input logic [31:0] tm, input logic [31:0] dt);
		names[i] = name;
		table_q[i] = {mi, hr, dy, wd, mo, yr, bad, skp, st, tm, dt};
	endtask

	// returns 2 ns after the n-th tick edge
	task automatic wait_ticks(input int n);
		int cnt;
		int guard;
		cnt = 0;
		guard = 0;
		while (cnt < n)
		begin
			@(posedge clk);
			if (tick)
				cnt++;
			guard++;
			if (guard > 4 * n + 8)
				abort_run("tick enable stopped running");
		end
		#2;
	endtask

	task automatic send_second(input logic b);
		rx = 1'b1;
		wait_ticks(b ? 20 : 10);
		rx = 1'b0;
		wait_ticks(b ? 80 : 90);
	endtask

	task automatic wait_frame_done();
		int guard;
		guard = 0;
		@(negedge clk);
		while (uut.rx_status.frame_done !== 1'b1)
		begin
			guard++;
			if (guard > 400)
				abort_run("no minute mark seen after the start pulse");
			@(negedge clk);
		end
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#2 apb_req = {1'b1, 1'b0, wr, addr, wdata}; // setup phase
		@(posedge clk);
		#2 apb_req.penable = 1'b1;
		@(negedge clk);
		check_value("pready", 32'h1, {31'h0, apb_rsp.pready});
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clk);
		#2 apb_req = '0;
	endtask

	task automatic check_entry(input int i);
		logic [31:0] rd;
		logic        err;
		entry_t      e;
		e = table_q[i];
		repeat (3) @(posedge clk);
		apb_access(1'b0, `APB_ADDR_STATUS, 32'h0, rd, err);
		check_value({names[i], " status"}, e.exp_status, rd);
		apb_access(1'b0, `APB_ADDR_TIME, 32'h0, rd, err);
		check_value({names[i], " time"}, e.exp_time, rd);
		apb_access(1'b0, `APB_ADDR_DATE, 32'h0, rd, err);
		check_value({names[i], " date"}, e.exp_date, rd);
		if (!e.corrupt && !e.skip)
		begin
			apb_access(1'b0, `APB_ADDR_FRAME_LO, 32'h0, rd, err);
			check_value({names[i], " frame_lo"}, sent_word[i][31:0], rd);
			apb_access(1'b0, `APB_ADDR_FRAME_HI, 32'h0, rd, err);
			check_value({names[i], " frame_hi"}, {5'h0, sent_word[i][58:32]}, rd);
		end
	endtask

	initial
	begin
		logic [31:0] rd;
		logic        err;
		reset = 1'b1;
		tick = 1'b0;
		rx = 1'b0;
		apb_req = '0;
		rng_state = 32'd7;
		// status is {valid count, error count, locked, error}
		set_entry(0, "valid_a", 7'h34, 6'h12, 6'h15, 3'd3, 5'h06, 8'h24, 1'b0, 1'b0,
			32'h00010006, 32'h00123400, 32'h24060315);
		set_entry(1, "corrupt", 7'h35, 6'h12, 6'h15, 3'd3, 5'h06, 8'h24, 1'b1, 1'b0,
			32'h0001000b, 32'h00123500, 32'h24060315);
		set_entry(2, "valid_b", 7'h58, 6'h23, 6'h31, 3'd7, 5'h12, 8'h99, 1'b0, 1'b0,
			32'h0002000a, 32'h00235800, 32'h99120731);
		set_entry(3, "hold_2359", 7'h00, 6'h00, 6'h00, 3'd0, 5'h00, 8'h00, 1'b0, 1'b1,
			32'h0002000f, 32'h00235900, 32'h99120731);
		set_entry(4, "hold_0000", 7'h00, 6'h00, 6'h00, 3'd0, 5'h00, 8'h00, 1'b0, 1'b1,
			32'h00020013, 32'h00000000, 32'h99120731);
		set_entry(5, "valid_c", 7'h59, 6'h09, 6'h01, 3'd1, 5'h01, 8'h00, 1'b0, 1'b0,
			32'h00030012, 32'h00095900, 32'h00010101);
		set_entry(6, "hold_1000", 7'h00, 6'h00, 6'h00, 3'd0, 5'h00, 8'h00, 1'b0, 1'b1,
			32'h00030017, 32'h00100000, 32'h00010101);
		repeat (5) @(posedge clk);
		#2 reset = 1'b0;

		apb_access(1'b0, `APB_ADDR_STATUS, 32'h0, rd, err);
		check_value("reset status", 32'h00000001, rd);
		apb_access(1'b0, `APB_ADDR_TIME, 32'h0, rd, err);
		check_value("reset time", 32'h0, rd);
		apb_access(1'b0, `APB_ADDR_DATE, 32'h0, rd, err);
		check_value("reset date", 32'h0, rd);
		wait_ticks(200); // quiet lead-in so the first start pulse closes a bad frame

		// each start pulse closes the previous minute
		for (int i = 0; i <= N_TESTS; i++)
		begin
			if (i < N_TESTS)
			begin
				rng_state = xorshift32(rng_state);
				sent_word[i] = encode_frame(table_q[i], rng_state[13:0]);
			end
			fork
				send_second(1'b0);
				begin
					wait_frame_done();
					if (i > 0)
						check_entry(i - 1);
				end
			join
			if (i < N_TESTS)
			begin
				for (int s = 1; s < 59; s++)
				begin
					if (table_q[i].skip)
						wait_ticks(100);
					else
						send_second(sent_word[i][s]);
				end
				wait_ticks(100); // second 59 has no pulse
			end
		end

		apb_access(1'b1, `APB_ADDR_CTRL, 32'h1, rd, err);
		check_value("ctrl write pslverr", 32'h0, {31'h0, err});
		apb_access(1'b0, `APB_ADDR_STATUS, 32'h0, rd, err);
		check_value("cleared status", 32'h00000003, rd);
		apb_access(1'b0, 8'h20, 32'h0, rd, err);
		check_value("unmapped read pslverr", 32'h1, {31'h0, err});
		apb_access(1'b1, `APB_ADDR_TIME, 32'h5, rd, err);
		check_value("time write pslverr", 32'h1, {31'h0, err});

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/dcf77_frame_pkg.sv
verilog/clock_pkg.sv
verilog/dcf77_receiver.sv
verilog/local_clock.sv
verilog/time_assembler.sv
verilog/apb_time_regs.sv
verilog/dcf77_top.sv
testbench/dcf77_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcf77_tb
FLAGS     ?= --binary --timing
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
